//--- hw/me_pkg.sv
/*
 * Datapath geometry for the block-matching engine.
 * Pixel, block and window types shared by the buffers, the SAD array and the top level.
 */
`default_nettype none

package me_pkg;

    localparam int PIX_W        = 8;
    localparam int BLK_N        = 4;
    localparam int WIN_N        = 8;
    localparam int PIX_PER_WORD = 4;
    localparam int NUM_CAND     = 16;
    // 16 x 255 = 4080 fits in 12 bits
    localparam int SAD_W        = 12;
    localparam int COORD_W      = 8;
    localparam int RESULT_W     = SAD_W + COORD_W;

    typedef logic [PIX_W-1:0] pixel_t;

    // Pixel k in byte k, lowest byte first
    typedef pixel_t [PIX_PER_WORD-1:0] word_t;

    // Row-major, index = row * side + col
    typedef pixel_t [BLK_N*BLK_N-1:0] block_t;
    typedef pixel_t [WIN_N*WIN_N-1:0] window_t;

    typedef logic [SAD_W-1:0] sad_t;

    // dy in the upper nibble, dx in the lower nibble
    typedef logic [COORD_W-1:0] coord_t;

endpackage

`default_nettype wire

//--- hw/me_ctrl_pkg.sv
/*
 * Control encodings for the block-matching engine.
 * Holds the controller states and the word counts of one input frame.
 */
`default_nettype none

package me_ctrl_pkg;

    typedef enum logic [2:0] {
        IDLE,
        LOAD_BLOCK,
        LOAD_WINDOW,
        SEARCH,
        SEND
    } ctrl_state_t;

    // Block rows first, then two words per window row
    localparam int BLOCK_WORDS  = 4;
    localparam int WINDOW_WORDS = 16;

endpackage

`default_nettype wire

//--- hw/me_ctrl.sv
/*
 * Frame sequencer. Accepts input words over valid/ready, steers them to the
 * block or window buffer, starts the search and waits for the result to be sent.
 */
`timescale 1ns/1ns
`default_nettype none

module me_ctrl import me_ctrl_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire        in_valid,
    output logic       in_ready,
    output logic       blk_we,
    output logic       win_we,
    output logic [3:0] word_idx,
    output logic       search_start,
    input  wire        serial_last
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    logic        blk_last;
    logic        win_last;

    assign in_ready = (state == LOAD_BLOCK) || (state == LOAD_WINDOW);
    assign blk_we   = (state == LOAD_BLOCK) && in_valid;
    assign win_we   = (state == LOAD_WINDOW) && in_valid;
    assign blk_last = blk_we && (word_idx == 4'(BLOCK_WORDS - 1));
    assign win_last = win_we && (word_idx == 4'(WINDOW_WORDS - 1));

    // SEARCH lasts one cycle, the array takes over from there
    assign search_start = (state == SEARCH);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:        state_nxt = LOAD_BLOCK;
            LOAD_BLOCK:  if (blk_last) state_nxt = LOAD_WINDOW;
            LOAD_WINDOW: if (win_last) state_nxt = SEARCH;
            SEARCH:      state_nxt = SEND;
            SEND:        if (serial_last) state_nxt = LOAD_BLOCK;
            default:     state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            word_idx <= '0;
        end else begin
            state <= state_nxt;
            // Word index restarts at each phase change
            if (blk_last || win_last) begin
                word_idx <= '0;
            end else if (blk_we || win_we) begin
                word_idx <= word_idx + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/block_buffer.sv
/*
 * Current-block store. Each written word fills one 4-pixel row of the block,
 * which stays in place for the search that follows.
 */
`timescale 1ns/1ns
`default_nettype none

module block_buffer import me_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire        we,
    input  wire  [3:0] word_idx,
    input  word_t      wdata,
    output block_t     blk
);

    logic [3:0] row_base;

    // Only rows 0 to 3 exist
    assign row_base = {word_idx[1:0], 2'b00};

    always_ff @(posedge clk) begin
        if (rst) begin
            blk <= '0;
        end else if (we) begin
            blk[row_base +: PIX_PER_WORD] <= wdata;
        end
    end

endmodule

`default_nettype wire

//--- hw/window_buffer.sv
/*
 * Search-window store. Two words make one 8-pixel row, lower half first.
 * The window is kept until the next frame writes over it.
 */
`timescale 1ns/1ns
`default_nettype none

module window_buffer import me_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire        we,
    input  wire  [3:0] word_idx,
    input  word_t      wdata,
    output window_t    win
);

    logic [2:0] row;
    logic       half;
    logic [5:0] pix_base;

    assign row  = word_idx[3:1];
    assign half = word_idx[0];

    // row * 8 + half * 4
    assign pix_base = {row, half, 2'b00};

    always_ff @(posedge clk) begin
        if (rst) begin
            win <= '0;
        end else if (we) begin
            win[pix_base +: PIX_PER_WORD] <= wdata;
        end
    end

endmodule

`default_nettype wire

//--- hw/sad_pe.sv
/*
 * One processing element. Sums the absolute differences of 16 pixel pairs
 * through a balanced adder tree and registers the total on load.
 */
`timescale 1ns/1ns
`default_nettype none

module sad_pe import me_pkg::*; (
    input  wire    clk,
    input  wire    load,
    input  block_t blk,
    input  block_t cand,
    output sad_t   sad
);

    pixel_t           diff [BLK_N*BLK_N];
    logic [PIX_W:0]   s1 [8];
    logic [PIX_W+1:0] s2 [4];
    logic [PIX_W+2:0] s3 [2];

    always_comb begin
        for (int i = 0; i < BLK_N * BLK_N; i++) begin
            diff[i] = (blk[i] > cand[i]) ? blk[i] - cand[i] : cand[i] - blk[i];
        end
        for (int i = 0; i < 8; i++) begin
            s1[i] = (PIX_W+1)'(diff[2*i]) + (PIX_W+1)'(diff[2*i+1]);
        end
        for (int i = 0; i < 4; i++) begin
            s2[i] = (PIX_W+2)'(s1[2*i]) + (PIX_W+2)'(s1[2*i+1]);
        end
        for (int i = 0; i < 2; i++) begin
            s3[i] = (PIX_W+3)'(s2[2*i]) + (PIX_W+3)'(s2[2*i+1]);
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            sad <= SAD_W'(s3[0]) + SAD_W'(s3[1]);
        end
    end

endmodule

`default_nettype wire

//--- hw/sad_array.sv
/*
 * Parallel SAD array with a sequential minimum search.
 * All 16 displacements are evaluated at once, then scanned one per cycle;
 * the lowest index wins a tie. result_valid pulses once the scan is done.
 */
`timescale 1ns/1ns
`default_nettype none

module sad_array import me_pkg::*; (
    input  wire     clk,
    input  wire     rst,
    input  wire     search_start,
    input  block_t  blk,
    input  window_t win,
    output logic    result_valid,
    output sad_t    result_sad,
    output coord_t  result_coord
);

    logic                        load_pe;
    logic                        scan_active;
    logic [$clog2(NUM_CAND)-1:0] scan_idx;
    logic [$clog2(NUM_CAND)-1:0] best_idx;
    sad_t                        pe_sad [NUM_CAND];
    sad_t                        cur_sad;
    sad_t                        best_sad;

    // Displacements 0 to 3 in each direction, candidate index dy * 4 + dx
    for (genvar dy = 0; dy < BLK_N; dy++) begin : g_dy
        for (genvar dx = 0; dx < BLK_N; dx++) begin : g_dx
            block_t cand;

            for (genvar r = 0; r < BLK_N; r++) begin : g_row
                for (genvar c = 0; c < BLK_N; c++) begin : g_col
                    assign cand[r*BLK_N + c] = win[(dy + r)*WIN_N + dx + c];
                end
            end

            sad_pe pe_1 (
                .clk  (clk),
                .load (load_pe),
                .blk  (blk),
                .cand (cand),
                .sad  (pe_sad[dy*BLK_N + dx])
            );
        end
    end

    assign cur_sad = pe_sad[scan_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            load_pe      <= 1'b0;
            scan_active  <= 1'b0;
            scan_idx     <= '0;
            result_valid <= 1'b0;
        end else begin
            load_pe      <= search_start;
            result_valid <= scan_active && (scan_idx == NUM_CAND - 1);
            if (load_pe) begin
                scan_active <= 1'b1;
                scan_idx    <= '0;
            end else if (scan_active) begin
                scan_idx <= scan_idx + 1'b1;
                if (scan_idx == NUM_CAND - 1) begin
                    scan_active <= 1'b0;
                end
            end
        end
    end

    // Strictly smaller only, so earlier candidates keep ties
    always_ff @(posedge clk) begin
        if (scan_active && (scan_idx == '0 || cur_sad < best_sad)) begin
            best_sad <= cur_sad;
            best_idx <= scan_idx;
        end
    end

    assign result_sad   = best_sad;
    assign result_coord = {2'b00, best_idx[3:2], 2'b00, best_idx[1:0]};

endmodule

`default_nettype wire

//--- hw/result_serializer.sv
/*
 * Serial result port. Loads SAD and coordinate on result_valid and shifts the
 * 20 bits out MSB first, SAD before coordinate, with serial_valid high throughout.
 */
`timescale 1ns/1ns
`default_nettype none

module result_serializer import me_pkg::*; (
    input  wire    clk,
    input  wire    rst,
    input  wire    result_valid,
    input  sad_t   result_sad,
    input  coord_t result_coord,
    output logic   serial_out,
    output logic   serial_valid,
    output logic   serial_last
);

    logic [RESULT_W-1:0]         shreg;
    logic [$clog2(RESULT_W)-1:0] bit_cnt;

    assign serial_out  = shreg[RESULT_W-1];
    assign serial_last = serial_valid && (bit_cnt == RESULT_W - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            serial_valid <= 1'b0;
            bit_cnt      <= '0;
        end else if (result_valid) begin
            serial_valid <= 1'b1;
            bit_cnt      <= '0;
        end else if (serial_valid) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (serial_last) begin
                serial_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (result_valid) begin
            shreg <= {result_sad, result_coord};
        end else if (serial_valid) begin
            shreg <= {shreg[RESULT_W-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

//--- hw/me_top.sv
/*
 * Full-search block-matching engine, top level.
 * Takes a 4x4 block and an 8x8 window as 20 words and returns the best
 * SAD and displacement as a 20-bit serial stream.
 */
`timescale 1ns/1ns
`default_nettype none

module me_top import me_pkg::*; (
    input  wire   clk,
    input  wire   rst,
    input  wire   in_valid,
    input  word_t in_data,
    output logic  in_ready,
    output logic  serial_out,
    output logic  serial_valid
);

    logic       blk_we;
    logic       win_we;
    logic [3:0] word_idx;
    logic       search_start;
    logic       serial_last;
    block_t     blk;
    window_t    win;
    logic       result_valid;
    sad_t       result_sad;
    coord_t     result_coord;

    me_ctrl ctrl_1 (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .blk_we       (blk_we),
        .win_we       (win_we),
        .word_idx     (word_idx),
        .search_start (search_start),
        .serial_last  (serial_last)
    );

    block_buffer block_buffer_1 (
        .clk      (clk),
        .rst      (rst),
        .we       (blk_we),
        .word_idx (word_idx),
        .wdata    (in_data),
        .blk      (blk)
    );

    window_buffer window_buffer_1 (
        .clk      (clk),
        .rst      (rst),
        .we       (win_we),
        .word_idx (word_idx),
        .wdata    (in_data),
        .win      (win)
    );

    sad_array sad_array_1 (
        .clk          (clk),
        .rst          (rst),
        .search_start (search_start),
        .blk          (blk),
        .win          (win),
        .result_valid (result_valid),
        .result_sad   (result_sad),
        .result_coord (result_coord)
    );

    result_serializer result_serializer_1 (
        .clk          (clk),
        .rst          (rst),
        .result_valid (result_valid),
        .result_sad   (result_sad),
        .result_coord (result_coord),
        .serial_out   (serial_out),
        .serial_valid (serial_valid),
        .serial_last  (serial_last)
    );

endmodule

`default_nettype wire

//--- bench/me_tb_asserts.sv
/*
 * Protocol checks for the block-matching engine.
 * Bound to me_top from the testbench to watch the input ready and the serial port.
 */
`timescale 1ns/1ns
`default_nettype none

module me_tb_asserts (
    input wire clk,
    input wire rst,
    input wire in_ready,
    input wire serial_valid,
    input wire serial_out
);

    // Consecutive cycles with serial_valid high so far
    logic [4:0] valid_run;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_run <= '0;
        end else if (serial_valid) begin
            valid_run <= valid_run + 1'b1;
        end else begin
            valid_run <= '0;
        end
    end

    no_ready_while_sending: assert property (@(posedge clk) disable iff (rst)
        !(in_ready && serial_valid))
        else $error("in_ready high while serial_valid is high");

    valid_not_too_long: assert property (@(posedge clk) disable iff (rst)
        serial_valid |-> (valid_run < 5'd20))
        else $error("serial_valid high for more than 20 cycles");

    valid_full_length: assert property (@(posedge clk) disable iff (rst)
        $fell(serial_valid) |-> (valid_run == 5'd20))
        else $error("serial_valid burst shorter than 20 cycles");

    serial_out_known: assert property (@(posedge clk) disable iff (rst)
        serial_valid |-> !$isunknown(serial_out))
        else $error("serial_out unknown while serial_valid is high");

endmodule

`default_nettype wire

//--- bench/me_tb.sv
/*
 * Directed testbench for the block-matching engine. Sends whole frames to
 * me_top, collects the 20-bit serial result and compares it with a
 * full-search reference model.
 */
`timescale 1ns/1ns
`default_nettype none

module me_tb import me_pkg::*; ();

    logic       clk = 1'b0;
    logic       rst;
    logic       in_valid;
    word_t      in_data;
    logic       in_ready;
    logic       serial_out;
    logic       serial_valid;

    logic [7:0] blk_pix [16];
    logic [7:0] win_pix [64];
    bit         use_gaps;
    bit         hold_marker;
    int         errors;
    int         timeouts;

    always #2 clk = ~clk;

    me_top DUT (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .in_ready     (in_ready),
        .serial_out   (serial_out),
        .serial_valid (serial_valid)
    );

    bind me_top me_tb_asserts asserts_1 (
        .clk          (clk),
        .rst          (rst),
        .in_ready     (in_ready),
        .serial_valid (serial_valid),
        .serial_out   (serial_out)
    );

    task automatic check_value(string name, int actual, int expected);
        assert (actual == expected) else begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0d, expected %0d",
                     $time, name, actual, expected);
        end
    endtask

    // Full search over dy, dx in 0..3, first minimum wins
    task automatic ref_model(output int best_sad, output int best_coord);
        int sad;
        int d;
        best_sad = -1;
        best_coord = 0;
        for (int dy = 0; dy < 4; dy++) begin
            for (int dx = 0; dx < 4; dx++) begin
                sad = 0;
                for (int r = 0; r < 4; r++) begin
                    for (int c = 0; c < 4; c++) begin
                        d = int'(blk_pix[r*4 + c]) - int'(win_pix[(dy + r)*8 + dx + c]);
                        sad += (d < 0) ? -d : d;
                    end
                end
                if (best_sad < 0 || sad < best_sad) begin
                    best_sad = sad;
                    best_coord = dy*16 + dx;
                end
            end
        end
    endtask

    task automatic fill_uniform(int blk_val, int win_val);
        foreach (blk_pix[i]) blk_pix[i] = 8'(blk_val);
        foreach (win_pix[i]) win_pix[i] = 8'(win_val);
    endtask

    task automatic fill_random();
        foreach (blk_pix[i]) blk_pix[i] = 8'($urandom_range(255));
        foreach (win_pix[i]) win_pix[i] = 8'($urandom_range(255));
    endtask

    // Called and returns one time unit after a rising edge
    task automatic send_frame();
        word_t w;
        int    waited;
        int    gap;
        for (int i = 0; i < 20; i++) begin
            for (int k = 0; k < 4; k++) begin
                w[k] = (i < 4) ? blk_pix[i*4 + k]
                               : win_pix[((i - 4) / 2)*8 + ((i - 4) % 2)*4 + k];
            end
            if (use_gaps) begin
                gap = $urandom_range(2);
                in_valid = 1'b0;
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
            end
            in_valid = 1'b1;
            in_data = w;
            waited = 0;
            while (!in_ready && waited < 100) begin
                @(posedge clk);
                #1;
                waited++;
            end
            if (!in_ready) begin
                timeouts++;
                $display("Timeout: in_ready stayed low while offering word %0d", i);
            end
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
    endtask

    task automatic collect_result(output int sad, output int coord);
        logic [19:0] bits;
        int          waited;
        bits = '0;
        waited = 0;
        while (!serial_valid && waited < 300) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!serial_valid) begin
            timeouts++;
            $display("Timeout: no serial result appeared after the frame was sent");
            sad = -1;
            coord = -1;
        end else begin
            for (int b = 0; b < 20; b++) begin
                check_value("serial_valid", int'(serial_valid), 1);
                check_value("in_ready", int'(in_ready), 0);
                bits = {bits[18:0], serial_out};
                @(posedge clk);
                #1;
            end
            check_value("serial_valid", int'(serial_valid), 0);
            sad = int'(bits[19:8]);
            coord = int'(bits[7:0]);
        end
    endtask

    task automatic run_frame(string tag, output int got_sad, output int got_coord);
        int exp_sad;
        int exp_coord;
        ref_model(exp_sad, exp_coord);
        send_frame();
        // Marker word offered while the engine is busy must never be taken
        if (hold_marker) begin
            in_valid = 1'b1;
            in_data = 32'hDEAD_BEEF;
        end
        collect_result(got_sad, got_coord);
        in_valid = 1'b0;
        check_value({tag, " sad"}, got_sad, exp_sad);
        check_value({tag, " coord"}, got_coord, exp_coord);
    endtask

    task automatic reset_state();
        check_value("serial_valid", int'(serial_valid), 0);
        check_value("in_ready", int'(in_ready), 0);
        @(posedge clk);
        #1;
        check_value("in_ready", int'(in_ready), 1);
    endtask

    task automatic exact_match();
        int s;
        int c;
        fill_uniform(0, 255);
        foreach (blk_pix[i]) blk_pix[i] = 8'($urandom_range(254));
        for (int r = 0; r < 4; r++) begin
            for (int k = 0; k < 4; k++) begin
                win_pix[(2 + r)*8 + 1 + k] = blk_pix[r*4 + k];
            end
        end
        run_frame("exact", s, c);
        check_value("exact fixed sad", s, 0);
        check_value("exact fixed coord", c, 'h21);
    endtask

    task automatic tie_break();
        int s;
        int c;
        fill_uniform(100, 90);
        run_frame("tie", s, c);
        check_value("tie fixed sad", s, 160);
        check_value("tie fixed coord", c, 0);
    endtask

    task automatic max_sad();
        int s;
        int c;
        fill_uniform(255, 0);
        run_frame("max", s, c);
        check_value("max fixed sad", s, 4080);
        check_value("max fixed coord", c, 0);
    endtask

    task automatic random_frames();
        int s;
        int c;
        use_gaps = 1'b1;
        repeat (6) begin
            fill_random();
            run_frame("random", s, c);
        end
        use_gaps = 1'b0;
    endtask

    task automatic stall_while_busy();
        int s;
        int c;
        fill_random();
        hold_marker = 1'b1;
        run_frame("stall", s, c);
        hold_marker = 1'b0;
        fill_random();
        run_frame("after stall", s, c);
    endtask

    initial begin
        void'($urandom(37740));
        rst = 1'b1;
        in_valid = 1'b0;
        in_data = '0;
        use_gaps = 1'b0;
        hold_marker = 1'b0;
        errors = 0;
        timeouts = 0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        reset_state();
        exact_match();
        tie_break();
        max_sad();
        random_frames();
        stall_while_busy();

        $display("Summary: %0d check failures, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- me_search.f
hw/me_pkg.sv
hw/me_ctrl_pkg.sv
hw/me_ctrl.sv
hw/block_buffer.sv
hw/window_buffer.sv
hw/sad_pe.sv
hw/sad_array.sv
hw/result_serializer.sv
hw/me_top.sv
bench/me_tb_asserts.sv
bench/me_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the me_search testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module me_tb -f me_search.f -o me_sim

status=0
out=$(./obj_dir/me_sim) || status=$?
printf '%s\n' "$out"

if [ "$status" -eq 0 ] && printf '%s\n' "$out" | grep -qx '>>> PASS'; then
    exit 0
fi
exit 1
